// ==== bench/nes_io_testdata.txt ====
# command, then four hex operands a b c d, unused ones 0
# expect a: 0 core_reset 1 loader_reset 2 joypad1_data 3 joypad2_data, b: value
expect 0 1 0 0
expect 1 1 0 0
expect 2 0 0 0
expect 3 0 0 0
# strobe a: multitap b: random pads, shift a: port clock falls
pads 5a c3 0f f0
strobe 0 0 0 0
shift 18 0 0 0
pads 81 7e 3c e7
strobe 0 0 0 0
shift 18 0 0 0
strobe 1 1 0 0
shift 18 0 0 0
strobe 1 1 0 0
shift 18 0 0 0
# download a: cycles with downloading high, b: busy cycles in the drain
download 4 0 0 0
download 6 40 0 0
fail 1 0 0 0
expect 0 1 0 0
fail 0 0 0 0
expect 0 0 0 0
ext 1 0 0 0
expect 0 1 0 0
ext 0 0 0 0
expect 0 0 0 0
hold 1 0 0 0
expect 0 1 0 0
hold 0 0 0 0
expect 0 0 0 0
expect 1 1 0 0
# sav_w a: 0 core 1 host 2 both, b: addr, c: byte, d: host byte on a collision
sav_w 1 10 a5 0
sav_r 0 10 a5 0
sav_w 0 7ff 3c 0
sav_r 1 7ff 3c 0
sav_w 2 123 c0 5e
sav_r 0 123 c0 0
sav_r 1 123 c0 0

// ==== bench/tb_nes_io.sv ====
`timescale 1ns/1ps
`include "nes_defs.svh"

module tb_nes_io;

  localparam logic [7:0] tap_sig_port1 = 8'h08;
  localparam logic [7:0] tap_sig_port2 = 8'h04;
  localparam int drain_limit = 300;
  localparam int restart_gap = 4;

  logic clk_ppu_21_47 = 1'b0;
  logic reset_nes;
  logic [7:0] pads [4];
  logic multitap_enabled;
  logic joypad_strobe;
  logic [1:0] joypad_clock;
  logic joypad1_data;
  logic joypad2_data;
  logic downloading;
  logic loader_busy;
  logic loader_fail;
  logic external_reset;
  logic hold_reset;
  logic core_reset;
  logic loader_reset;
  logic [10:0] bram_addr;
  logic [7:0] bram_wdata;
  logic bram_write;
  logic [7:0] bram_rdata;
  logic [10:0] sd_buff_addr;
  logic [7:0] sd_buff_wdata;
  logic sd_buff_wr;
  logic sd_buff_rd;
  logic [7:0] sd_buff_rdata;

  int mismatches = 0;
  int failures = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  logic [15:0] lfsr = 16'd77;
  logic [23:0] exp_rep1;
  logic [23:0] exp_rep2;
  logic [4:0] bit_idx;

  nes_io_top u_dut (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .p1_buttons       (pads[0]),
    .p2_buttons       (pads[1]),
    .p3_buttons       (pads[2]),
    .p4_buttons       (pads[3]),
    .multitap_enabled (multitap_enabled),
    .joypad_strobe    (joypad_strobe),
    .joypad_clock     (joypad_clock),
    .joypad1_data     (joypad1_data),
    .joypad2_data     (joypad2_data),
    .downloading      (downloading),
    .loader_busy      (loader_busy),
    .loader_fail      (loader_fail),
    .external_reset   (external_reset),
    .hold_reset       (hold_reset),
    .core_reset       (core_reset),
    .loader_reset     (loader_reset),
    .bram_addr        (bram_addr),
    .bram_wdata       (bram_wdata),
    .bram_write       (bram_write),
    .bram_rdata       (bram_rdata),
    .sd_buff_addr     (sd_buff_addr),
    .sd_buff_wdata    (sd_buff_wdata),
    .sd_buff_wr       (sd_buff_wr),
    .sd_buff_rd       (sd_buff_rd),
    .sd_buff_rdata    (sd_buff_rdata)
  );

  always #5 clk_ppu_21_47 = ~clk_ppu_21_47;

  // watchdog, limit set once the data file is counted
  always @(posedge clk_ppu_21_47) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: test commands still running after %0d cycles", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  // port report: main pad low, then extra pad and signature, or all ones
  function automatic logic [23:0] layout_report(input logic [7:0] main_pad,
                                                input logic [7:0] extra_pad,
                                                input logic [7:0] sig,
                                                input logic tap);
    logic [23:0] r;
    r[7:0] = main_pad;
    r[15:8] = tap ? extra_pad : 8'hff;
    r[23:16] = tap ? sig : 8'hff;
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatches++;
    $display("mismatch %s expected %0h actual %0h at %0t", name, expected, actual, $time);
  endtask

  task automatic check_data_bits();
    logic exp1;
    logic exp2;
    // past the last report bit only zeros remain
    exp1 = (bit_idx < 5'd24) ? exp_rep1[bit_idx] : 1'b0;
    exp2 = (bit_idx < 5'd24) ? exp_rep2[bit_idx] : 1'b0;
    if (joypad1_data !== exp1) begin
      report_mismatch("joypad1_data", 32'(exp1), 32'(joypad1_data));
    end
    if (joypad2_data !== exp2) begin
      report_mismatch("joypad2_data", 32'(exp2), 32'(joypad2_data));
    end
  endtask

  task automatic strobe_ports(input logic [31:0] mt, input logic [31:0] rnd);
    if (rnd != 0) begin
      for (int p = 0; p < 4; p++) begin
        draw_byte(pads[p]);
      end
    end
    multitap_enabled = mt[0];
    joypad_strobe = 1'b1;
    exp_rep1 = layout_report(pads[0], pads[2], tap_sig_port1, mt[0]);
    exp_rep2 = layout_report(pads[1], pads[3], tap_sig_port2, mt[0]);
    @(negedge clk_ppu_21_47);
    joypad_strobe = 1'b0;
    bit_idx = 5'd0;
    check_data_bits();
  endtask

  task automatic shift_ports(input logic [31:0] n);
    for (int i = 0; i < n; i++) begin
      joypad_clock = 2'b11;
      @(negedge clk_ppu_21_47);
      joypad_clock = 2'b00;
      // new bit shows two edges after the fall
      @(negedge clk_ppu_21_47);
      @(negedge clk_ppu_21_47);
      if (bit_idx < 5'd24) begin
        bit_idx = bit_idx + 5'd1;
      end
      check_data_bits();
    end
  endtask

  task automatic run_download(input logic [31:0] len, input logic [31:0] busy_len);
    int waited;
    // short download first, restarted while its drain runs
    downloading = 1'b1;
    @(negedge clk_ppu_21_47);
    downloading = 1'b0;
    for (int i = 0; i < restart_gap; i++) begin
      @(negedge clk_ppu_21_47);
      if (loader_reset !== 1'b0) begin
        report_mismatch("loader_reset", 32'h0, 32'(loader_reset));
      end
      if (core_reset !== 1'b1) begin
        report_mismatch("core_reset", 32'h1, 32'(core_reset));
      end
    end
    downloading = 1'b1;
    for (int i = 0; i < len; i++) begin
      @(negedge clk_ppu_21_47);
      // loader reset high on the first edge only
      if (loader_reset !== (i == 0)) begin
        report_mismatch("loader_reset", 32'(i == 0), 32'(loader_reset));
      end
      if (i > 0 && core_reset !== 1'b1) begin
        report_mismatch("core_reset", 32'h1, 32'(core_reset));
      end
    end
    downloading = 1'b0;
    loader_busy = (busy_len != 0);
    for (int i = 0; i < busy_len; i++) begin
      @(negedge clk_ppu_21_47);
      if (core_reset !== 1'b1) begin
        report_mismatch("core_reset", 32'h1, 32'(core_reset));
      end
    end
    loader_busy = 1'b0;
    waited = 0;
    while (core_reset === 1'b1 && waited < drain_limit) begin
      @(negedge clk_ppu_21_47);
      waited++;
      if (core_reset === 1'b1 && loader_reset !== 1'b0) begin
        report_mismatch("loader_reset", 32'h0, 32'(loader_reset));
      end
    end
    if (core_reset !== 1'b0) begin
      failures++;
      $display("core_reset was not released within %0d cycles of the drain", drain_limit);
    end else if (waited < `NES_DL_RESET_CYCLES) begin
      failures++;
      $display("core_reset was released after only %0d cycles of the drain", waited);
    end else if (loader_reset !== 1'b1) begin
      report_mismatch("loader_reset", 32'h1, 32'(loader_reset));
    end
  endtask

  task automatic check_output(input logic [31:0] sel, input logic [31:0] value);
    string name;
    logic actual;
    case (sel)
      0: begin
        name = "core_reset";
        actual = core_reset;
      end
      1: begin
        name = "loader_reset";
        actual = loader_reset;
      end
      2: begin
        name = "joypad1_data";
        actual = joypad1_data;
      end
      3: begin
        name = "joypad2_data";
        actual = joypad2_data;
      end
      default: begin
        failures++;
        $display("expect command names an unknown output %0h", sel);
        return;
      end
    endcase
    if (actual !== value[0]) begin
      report_mismatch(name, value, 32'(actual));
    end
  endtask

  // port 0 core, 1 host, 2 both on one edge
  task automatic save_write(input logic [31:0] port, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] host_data);
    if (port != 1) begin
      bram_addr = addr[10:0];
      bram_wdata = data[7:0];
      bram_write = 1'b1;
    end
    if (port != 0) begin
      sd_buff_addr = addr[10:0];
      sd_buff_wdata = (port == 2) ? host_data[7:0] : data[7:0];
      sd_buff_wr = 1'b1;
    end
    @(negedge clk_ppu_21_47);
    bram_write = 1'b0;
    sd_buff_wr = 1'b0;
  endtask

  task automatic save_read(input logic [31:0] port, input logic [31:0] addr,
                           input logic [31:0] expected);
    if (port == 0) begin
      bram_addr = addr[10:0];
    end else begin
      sd_buff_addr = addr[10:0];
      sd_buff_rd = 1'b1;
    end
    @(negedge clk_ppu_21_47);
    sd_buff_rd = 1'b0;
    if (port == 0 && bram_rdata !== expected[7:0]) begin
      report_mismatch("bram_rdata", expected, 32'(bram_rdata));
    end
    if (port != 0 && sd_buff_rdata !== expected[7:0]) begin
      report_mismatch("sd_buff_rdata", expected, 32'(sd_buff_rdata));
    end
  endtask

  initial begin
    int fd;
    int status;
    int lines;
    logic [8*128-1:0] line;
    logic [63:0] cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;

    reset_nes = 1'b1;
    for (int p = 0; p < 4; p++) begin
      pads[p] = 8'h00;
    end
    multitap_enabled = 1'b0;
    joypad_strobe = 1'b0;
    joypad_clock = 2'b00;
    downloading = 1'b0;
    loader_busy = 1'b0;
    loader_fail = 1'b0;
    external_reset = 1'b0;
    hold_reset = 1'b0;
    bram_addr = '0;
    bram_wdata = '0;
    bram_write = 1'b0;
    sd_buff_addr = '0;
    sd_buff_wdata = '0;
    sd_buff_wr = 1'b0;
    sd_buff_rd = 1'b0;

    fd = $fopen("bench/nes_io_testdata.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("could not open bench/nes_io_testdata.txt");
    end else begin
      lines = 0;
      while ($fgets(line, fd) != 0) begin
        lines++;
      end
      $fclose(fd);
      cycle_limit = lines * 400;
      fd = $fopen("bench/nes_io_testdata.txt", "r");
    end

    repeat (3) @(negedge clk_ppu_21_47);
    reset_nes = 1'b0;

    while (fd != 0 && $fgets(line, fd) != 0) begin
      cmd = '0;
      status = $sscanf(line, "%s %h %h %h %h", cmd, a, b, c, d);
      if (status <= 0 || cmd == 64'("#")) begin
        continue;
      end
      if (status != 5) begin
        failures++;
        $display("test data line is missing operands");
        continue;
      end
      case (cmd)
        64'("pads"): begin
          pads[0] = a[7:0];
          pads[1] = b[7:0];
          pads[2] = c[7:0];
          pads[3] = d[7:0];
        end
        64'("strobe"): strobe_ports(a, b);
        64'("shift"): shift_ports(a);
        64'("download"): run_download(a, b);
        64'("fail"): begin
          loader_fail = a[0];
          @(negedge clk_ppu_21_47);
        end
        64'("ext"): begin
          external_reset = a[0];
          @(negedge clk_ppu_21_47);
        end
        64'("hold"): begin
          hold_reset = a[0];
          @(negedge clk_ppu_21_47);
        end
        64'("sav_w"): save_write(a, b, c, d);
        64'("sav_r"): save_read(a, b, c);
        64'("expect"): check_output(a, b);
        default: begin
          failures++;
          $display("test data holds an unknown command");
        end
      endcase
    end

    $display("checks done, %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== hw/joypad_port.sv ====
`timescale 1ns/1ps
`include "nes_defs.svh"

module joypad_port (
  input  logic                       clk_ppu_21_47,
  input  logic                       reset_nes,
  input  logic                       strobe,
  input  logic                       port_clock,
  input  nes_input_pkg::port_report_t report,
  output logic                       data
);

  nes_input_pkg::port_report_t shift_reg;
  logic clock_prev;
  // falling edge of the port clock, seen one edge ago
  logic fall_seen;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      shift_reg  <= '0;
      clock_prev <= 1'b0;
      fall_seen  <= 1'b0;
    end else begin
      clock_prev <= port_clock;
      fall_seen  <= clock_prev & ~port_clock;
      // strobe wins over a pending shift
      if (strobe) begin
        shift_reg <= report;
      end else if (fall_seen) begin
        shift_reg <= {1'b0, shift_reg[`NES_PORT_REPORT_W-1:1]};
      end
    end
  end

  // current bit straight to the core
  assign data = shift_reg[0];

endmodule

// ==== hw/nes_defs.svh ====
`ifndef NES_DEFS_SVH
`define NES_DEFS_SVH

// controller side
`define NES_PAD_BUTTONS 8
`define NES_PORT_REPORT_W 24

// multitap signature bytes, shifted out after the second pad
`define NES_TAP_SIG_PORT1 8'h08
`define NES_TAP_SIG_PORT2 8'h04

// battery save memory
`define NES_SAVE_ADDR_W 11
`define NES_SAVE_DATA_W 8

// drain after a ROM download
`define NES_DL_RESET_CYCLES 255
`define NES_DL_CNT_W 8

`endif

// ==== hw/nes_input_pkg.sv ====
`include "nes_defs.svh"

package nes_input_pkg;

  // one pad, bit 0 is A
  // then B, select, start, up, down, left, right
  typedef logic [`NES_PAD_BUTTONS-1:0] pad_buttons_t;

  // full serial report for one port
  // bit 0 leaves first
  typedef logic [`NES_PORT_REPORT_W-1:0] port_report_t;

endpackage

// ==== hw/nes_io_top.sv ====
`timescale 1ns/1ps
`include "nes_defs.svh"

module nes_io_top (
  input  logic                        clk_ppu_21_47,
  input  logic                        reset_nes,

  // pads
  input  logic [`NES_PAD_BUTTONS-1:0] p1_buttons,
  input  logic [`NES_PAD_BUTTONS-1:0] p2_buttons,
  input  logic [`NES_PAD_BUTTONS-1:0] p3_buttons,
  input  logic [`NES_PAD_BUTTONS-1:0] p4_buttons,
  input  logic                        multitap_enabled,

  // joypad serial ports
  input  logic                        joypad_strobe,
  input  logic [1:0]                  joypad_clock,
  output logic                        joypad1_data,
  output logic                        joypad2_data,

  // download and reset
  input  logic                        downloading,
  input  logic                        loader_busy,
  input  logic                        loader_fail,
  input  logic                        external_reset,
  input  logic                        hold_reset,
  output logic                        core_reset,
  output logic                        loader_reset,

  // core save port
  input  logic [`NES_SAVE_ADDR_W-1:0] bram_addr,
  input  logic [`NES_SAVE_DATA_W-1:0] bram_wdata,
  input  logic                        bram_write,
  output logic [`NES_SAVE_DATA_W-1:0] bram_rdata,

  // host save buffer port
  input  logic [`NES_SAVE_ADDR_W-1:0] sd_buff_addr,
  input  logic [`NES_SAVE_DATA_W-1:0] sd_buff_wdata,
  input  logic                        sd_buff_wr,
  input  logic                        sd_buff_rd,
  output logic [`NES_SAVE_DATA_W-1:0] sd_buff_rdata
);

  logic [`NES_PORT_REPORT_W-1:0] port1_report;
  logic [`NES_PORT_REPORT_W-1:0] port2_report;

  save_port_if core_save ();
  save_port_if host_save ();

  pad_report_builder u_reports (
    .pad1             (p1_buttons),
    .pad2             (p2_buttons),
    .pad3             (p3_buttons),
    .pad4             (p4_buttons),
    .multitap_enabled (multitap_enabled),
    .port1_report     (port1_report),
    .port2_report     (port2_report)
  );

  joypad_port u_port1 (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .strobe        (joypad_strobe),
    .port_clock    (joypad_clock[0]),
    .report        (port1_report),
    .data          (joypad1_data)
  );

  joypad_port u_port2 (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .strobe        (joypad_strobe),
    .port_clock    (joypad_clock[1]),
    .report        (port2_report),
    .data          (joypad2_data)
  );

  reset_sequencer u_reset (
    .clk_ppu_21_47  (clk_ppu_21_47),
    .reset_nes      (reset_nes),
    .downloading    (downloading),
    .loader_busy    (loader_busy),
    .loader_fail    (loader_fail),
    .external_reset (external_reset),
    .hold_reset     (hold_reset),
    .core_reset     (core_reset),
    .loader_reset   (loader_reset)
  );

  // core side, reads every cycle
  assign core_save.addr  = bram_addr;
  assign core_save.wdata = bram_wdata;
  assign core_save.wr    = bram_write;
  assign core_save.rd    = 1'b1;
  assign bram_rdata      = core_save.rdata;

  // host save buffer side
  assign host_save.addr  = sd_buff_addr;
  assign host_save.wdata = sd_buff_wdata;
  assign host_save.wr    = sd_buff_wr;
  assign host_save.rd    = sd_buff_rd;
  assign sd_buff_rdata   = host_save.rdata;

  save_ram u_save (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .core          (core_save.memory),
    .host          (host_save.memory)
  );

endmodule

// ==== hw/nes_mem_pkg.sv ====
`include "nes_defs.svh"

package nes_mem_pkg;

  typedef logic [`NES_SAVE_ADDR_W-1:0] save_addr_t;
  typedef logic [`NES_SAVE_DATA_W-1:0] save_data_t;

  // download driven reset sequence
  typedef enum logic [1:0] {
    rst_await_rom,
    rst_loading,
    rst_drain,
    rst_run
  } reset_state_t;

endpackage

// ==== hw/pad_report_builder.sv ====
`timescale 1ns/1ps
`include "nes_defs.svh"

module pad_report_builder (
  input  nes_input_pkg::pad_buttons_t pad1,
  input  nes_input_pkg::pad_buttons_t pad2,
  input  nes_input_pkg::pad_buttons_t pad3,
  input  nes_input_pkg::pad_buttons_t pad4,
  input  logic                        multitap_enabled,
  output nes_input_pkg::port_report_t port1_report,
  output nes_input_pkg::port_report_t port2_report
);

  // layout rule for one port
  // main pad first, then either extra pad plus signature or all ones
  function automatic nes_input_pkg::port_report_t build_report(
    input nes_input_pkg::pad_buttons_t main_pad,
    input nes_input_pkg::pad_buttons_t extra_pad,
    input logic [7:0]                  signature,
    input logic                        tap
  );
    nes_input_pkg::port_report_t rpt;
    if (tap) begin
      rpt = {signature, extra_pad, main_pad};
    end else begin
      rpt = {{(`NES_PORT_REPORT_W - `NES_PAD_BUTTONS){1'b1}}, main_pad};
    end
    return rpt;
  endfunction

  assign port1_report = build_report(pad1, pad3, `NES_TAP_SIG_PORT1, multitap_enabled);
  assign port2_report = build_report(pad2, pad4, `NES_TAP_SIG_PORT2, multitap_enabled);

endmodule

// ==== hw/reset_sequencer.sv ====
`timescale 1ns/1ps
`include "nes_defs.svh"

module reset_sequencer (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic downloading,
  input  logic loader_busy,
  input  logic loader_fail,
  input  logic external_reset,
  input  logic hold_reset,
  output logic core_reset,
  output logic loader_reset
);

  nes_mem_pkg::reset_state_t state;
  logic [`NES_DL_CNT_W-1:0] drain_cnt;
  logic downloading_prev;
  logic dl_rise;

  assign dl_rise = downloading & ~downloading_prev;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state            <= nes_mem_pkg::rst_await_rom;
      drain_cnt        <= '0;
      downloading_prev <= 1'b0;
      core_reset       <= 1'b1;
      loader_reset     <= 1'b1;
    end else begin
      downloading_prev <= downloading;

      // a new download restarts the sequence from any state
      if (downloading) begin
        state     <= nes_mem_pkg::rst_loading;
        drain_cnt <= `NES_DL_CNT_W'(`NES_DL_RESET_CYCLES);
      end else begin
        case (state)
          nes_mem_pkg::rst_loading: begin
            state <= nes_mem_pkg::rst_drain;
          end
          nes_mem_pkg::rst_drain: begin
            if (drain_cnt == '0) begin
              state <= nes_mem_pkg::rst_run;
            end else if (!loader_busy) begin
              // loader still busy stretches the drain
              drain_cnt <= drain_cnt - `NES_DL_CNT_W'(1);
            end
          end
          default: begin
            state <= state;
          end
        endcase
      end

      core_reset <= (state != nes_mem_pkg::rst_run) | loader_fail | external_reset |
                    hold_reset;
      loader_reset <= (state == nes_mem_pkg::rst_await_rom) |
                      (state == nes_mem_pkg::rst_run) | dl_rise;
    end
  end

endmodule

// ==== hw/save_port_if.sv ====
`timescale 1ns/1ps

// one access port into the save RAM
interface save_port_if;

  nes_mem_pkg::save_addr_t addr;
  nes_mem_pkg::save_data_t wdata;
  logic wr;
  // advisory only, rdata follows addr every cycle
  logic rd;
  nes_mem_pkg::save_data_t rdata;

  modport requester (
    output addr,
    output wdata,
    output wr,
    output rd,
    input  rdata
  );

  modport memory (
    input  addr,
    input  wdata,
    input  wr,
    input  rd,
    output rdata
  );

endinterface

// ==== hw/save_ram.sv ====
`timescale 1ns/1ps
`include "nes_defs.svh"

module save_ram (
  input logic         clk_ppu_21_47,
  save_port_if.memory core,
  save_port_if.memory host
);

  localparam int unsigned DEPTH = 1 << `NES_SAVE_ADDR_W;

  // cartridge battery RAM
  nes_mem_pkg::save_data_t mem [DEPTH];

  logic same_addr_write;

  // core keeps its byte on a colliding write
  assign same_addr_write = core.wr & host.wr & (core.addr == host.addr);

  always_ff @(posedge clk_ppu_21_47) begin
    if (core.wr) begin
      mem[core.addr] <= core.wdata;
    end
    if (host.wr && !same_addr_write) begin
      mem[host.addr] <= host.wdata;
    end
  end

  // registered reads, old data on a same cycle write
  always_ff @(posedge clk_ppu_21_47) begin
    core.rdata <= mem[core.addr];
    host.rdata <= mem[host.addr];
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the nes_io testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module tb_nes_io -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_nes_io)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// ==== src.f ====
+incdir+hw
hw/nes_input_pkg.sv
hw/nes_mem_pkg.sv
hw/save_port_if.sv
hw/joypad_port.sv
hw/pad_report_builder.sv
hw/reset_sequencer.sv
hw/save_ram.sv
hw/nes_io_top.sv
bench/tb_nes_io.sv
